// File: filelist.f
src/cpu_cfg_pkg.sv
src/cpu_isa_pkg.sv
src/alu.sv
src/reg_file.sv
src/status_reg.sv
src/pc.sv
src/idec.sv
src/sequencer.sv
src/cpu.sv
tb/cpu_chk.sv
tb/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f filelist.f -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/cpu_tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

// File: tb/cpu_stimulus.txt
# M <addr> <count> <bytes> preloads memory, W <addr> <data> is the next expected write
# S <count> gives the opcode fetches before the final JMP to itself
M 0000 15 A9 5A A2 C3 A0 00 8D 00 02 8E 01 02 8C 02 02
M 000F 14 18 A9 70 69 20 8D 03 02 38 E9 10 8D 04 02
M 001D 15 29 F0 8D 05 02 09 0F 8D 06 02 49 FF 8D 07 02
M 002C 17 E8 8E 08 02 C8 8C 09 02 CA 88 8C 0A 02 8A 8D 0B 02
M 003D 12 A9 3C AA 8E 0C 02 A8 C8 98 8D 0D 02
M 0049 19 A2 80 9A 18 A9 FF 69 01 08 18 A9 7F 69 01 08 38 A9 00 08
M 005C 12 AD 00 03 8D 0E 02 4C 00 04 8D FF 02
M 0300 1 A7
M 0400 9 A2 5E 8E 0F 02 EA 4C 06 04
W 0200 5A
W 0201 C3
W 0202 00
W 0203 90
W 0204 80
W 0205 80
W 0206 8F
W 0207 70
W 0208 C4
W 0209 01
W 020A 00
W 020B C3
W 020C 3C
W 020D 3D
W 0180 23
W 017F E0
W 017E 63
W 020E A7
W 020F 5E
S 54

// File: tb/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

import cpu_cfg_pkg::*;

localparam real               HALF_PERIOD = 2.0;
localparam int                RESET_CYCLES = 16;
localparam int                RUN_LIMIT = 1000;
localparam int                FETCH_GAP_LIMIT = 8;
localparam int                SEED = 70490;
localparam logic [ADDR_W-1:0] START_ADDR = 16'h0000;
localparam string             STIM_FILE = "tb/cpu_stimulus.txt";

logic              clk;
logic              arst_n;
logic [DATA_W-1:0] rdata;
logic [ADDR_W-1:0] addr;
logic [DATA_W-1:0] wdata;
logic              we;
logic              sync;

logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
logic [ADDR_W-1:0] exp_addr [$];
logic [DATA_W-1:0] exp_data [$];
int                exp_syncs;

cpu #(
	.reset_vector_p (START_ADDR)
) dut (
	.clk_i    (clk),
	.arst_n_i (arst_n),
	.data_i   (rdata),
	.addr_o   (addr),
	.data_o   (wdata),
	.we_o     (we),
	.sync_o   (sync)
);

bind cpu cpu_chk chk (
	.clk_i    (clk_i),
	.arst_n_i (arst_n_i),
	.addr_i   (addr_o),
	.we_i     (we_o),
	.sync_i   (sync_o)
);

initial begin
	clk = 1'b0;
	forever #HALF_PERIOD clk = ~clk;
end

// Asynchronous-read memory that settles 1 ns after the edge
always @(posedge clk) begin
	#1;
	rdata = mem[addr];
end

task automatic abort_run(input string reason);
	$display("Failure at %0.2f ns: %s", $realtime, reason);
	$display("TESTS FAILED");
	$fatal(1, "Run stopped");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected) begin
		$display("Error at %0.2f ns: %s is 0x%0h, expected 0x%0h",
			$realtime, name, actual, expected);
		$display("TESTS FAILED");
		$fatal(1, "Value mismatch");
	end
endtask

// Cycle counts per instruction kind from fetch to fetch
function automatic int cycles_for_opcode(input logic [7:0] opc);
	case (opc)
		8'h08, 8'h4C: return 3;
		8'hAD, 8'h8D, 8'h8E, 8'h8C: return 4;
		default: return 2;
	endcase
endfunction

// JMP to its own address ends the program
function automatic logic is_end_marker(input logic [ADDR_W-1:0] a);
	return (mem[a] == 8'h4C) && (mem[a + 16'd1] == a[7:0]) &&
		(mem[a + 16'd2] == a[15:8]);
endfunction

task automatic load_stimulus();
	int                fd;
	int                rc;
	int                count;
	int                i;
	logic [8*8-1:0]    tag;
	logic [8*128-1:0]  rest;
	logic [ADDR_W-1:0] a;
	logic [DATA_W-1:0] d;
	fd = $fopen(STIM_FILE, "r");
	if (fd == 0)
		abort_run("cannot open the stimulus file");
	exp_syncs = -1;
	rc = $fscanf(fd, "%s", tag);
	while (rc == 1) begin
		if (tag == "#") begin
			rc = $fgets(rest, fd);
		end else if (tag == "M") begin
			rc = $fscanf(fd, "%h %d", a, count);
			if (rc != 2)
				abort_run("malformed memory line in the stimulus file");
			for (i = 0; i < count; i++) begin
				rc = $fscanf(fd, "%h", d);
				if (rc != 1)
					abort_run("memory line is shorter than its byte count");
				mem[a + ADDR_W'(i)] = d;
			end
		end else if (tag == "W") begin
			rc = $fscanf(fd, "%h %h", a, d);
			if (rc != 2)
				abort_run("malformed write line in the stimulus file");
			exp_addr.push_back(a);
			exp_data.push_back(d);
		end else if (tag == "S") begin
			rc = $fscanf(fd, "%d", exp_syncs);
			if (rc != 1)
				abort_run("malformed sync count line in the stimulus file");
		end else begin
			abort_run("unknown line type in the stimulus file");
		end
		rc = $fscanf(fd, "%s", tag);
	end
	$fclose(fd);
	if (exp_syncs < 0)
		abort_run("the stimulus file gives no sync count");
endtask

initial begin
	int                cycles;
	int                since_sync;
	int                syncs;
	int                i;
	logic              seen_sync;
	logic              done;
	logic [DATA_W-1:0] last_op;
	logic [ADDR_W-1:0] want_addr;
	logic [DATA_W-1:0] want_data;
	arst_n = 1'b0;
	rdata = '0;
	void'($urandom(SEED));
	for (i = 0; i < (1 << ADDR_W); i++)
		mem[i] = DATA_W'($urandom());
	load_stimulus();
	repeat (RESET_CYCLES) @(posedge clk);
	#1;
	arst_n = 1'b1;

	cycles = 0;
	since_sync = 0;
	syncs = 0;
	seen_sync = 1'b0;
	done = 1'b0;
	last_op = '0;
	// Sample mid-cycle where the bus is stable
	while (!done) begin
		@(negedge clk);
		cycles++;
		since_sync++;
		if (cycles > RUN_LIMIT)
			abort_run("the program did not reach its end marker within the cycle limit");
		if (since_sync > FETCH_GAP_LIMIT)
			abort_run("no opcode fetch was seen for too many cycles");
		if (we) begin
			if (exp_addr.size() == 0)
				abort_run("a write happened after all expected writes");
			want_addr = exp_addr.pop_front();
			want_data = exp_data.pop_front();
			check_value("addr_o", addr, want_addr);
			check_value("data_o", wdata, want_data);
			mem[addr] = wdata;
		end
		if (sync) begin
			if (seen_sync)
				check_value("sync_o interval", since_sync, cycles_for_opcode(last_op));
			else
				check_value("addr_o at first fetch", addr, START_ADDR);
			seen_sync = 1'b1;
			since_sync = 0;
			if (is_end_marker(addr)) begin
				done = 1'b1;
			end else begin
				syncs++;
				last_op = mem[addr];
			end
		end
	end

	check_value("sync_o count", syncs, exp_syncs);
	if (exp_addr.size() != 0) begin
		abort_run("some expected writes never happened");
	end else begin
		$display("TESTS PASSED");
		$finish;
	end
end

endmodule

// File: tb/cpu_chk.sv
`timescale 1ns/10ps

module cpu_chk (
	input logic                           clk_i,
	input logic                           arst_n_i,
	input logic [cpu_cfg_pkg::ADDR_W-1:0] addr_i,
	input logic                           we_i,
	input logic                           sync_i
);

// Opcode fetch is always a read
fetch_not_write: assert property (
	@(posedge clk_i) disable iff (!arst_n_i) !(we_i && sync_i)
) else $error("we_o and sync_o were high in the same cycle");

// Every instruction takes at least two cycles
sync_single_cycle: assert property (
	@(posedge clk_i) disable iff (!arst_n_i) sync_i |=> !sync_i
) else $error("sync_o was high in two consecutive cycles");

addr_known: assert property (
	@(posedge clk_i) disable iff (!arst_n_i) !$isunknown(addr_i)
) else $error("addr_o carried unknown bits after reset");

endmodule

// File: src/cpu.sv
`timescale 1ns/10ps

module cpu #(
	parameter logic [cpu_cfg_pkg::ADDR_W-1:0] reset_vector_p = cpu_cfg_pkg::RESET_VECTOR
) (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] data_i,
	output logic [cpu_cfg_pkg::ADDR_W-1:0] addr_o,
	output logic [cpu_cfg_pkg::DATA_W-1:0] data_o,
	output logic                           we_o,
	output logic                           sync_o
);

import cpu_cfg_pkg::*;
import cpu_isa_pkg::*;

logic [DATA_W-1:0] ir_q;
logic [DATA_W-1:0] opcode;
logic              ir_we;
opcode_e           op;
mode_e             mode;
reg_sel_e          src;
reg_sel_e          dst;
reg_sel_e          reg_we_sel;
reg_sel_e          reg_rd_sel;
logic              adl_we;
logic              adh_we;
logic              sp_dec;
logic              pc_inc;
logic              pc_load;
alu_func_e         alu_func;
alu_src_e          alu_src;
logic [DATA_W-1:0] st_mask;
logic [DATA_W-1:0] st_set;
logic [DATA_W-1:0] st_clr;
addr_sel_e         addr_sel;
logic              data_sel;
logic [DATA_W-1:0] alu_a;
logic [DATA_W-1:0] alu_y;
logic              alu_carry;
logic              alu_sign;
logic              alu_zero;
logic              alu_ovf;
logic [DATA_W-1:0] rd;
logic [DATA_W-1:0] adl;
logic [DATA_W-1:0] adh;
logic [DATA_W-1:0] sp;
logic [DATA_W-1:0] p;
logic [ADDR_W-1:0] pc_addr;

// Instruction register
always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i)
		ir_q <= '0;
	else if (ir_we)
		ir_q <= data_i;
end

// Decode the bus byte during fetch, the latched opcode afterwards
assign opcode = ir_we ? data_i : ir_q;

always_comb begin
	case (alu_src)
		SRC_REG:  alu_a = rd;
		SRC_DATA: alu_a = data_i;
		default:  alu_a = '0;
	endcase
end

always_comb begin
	case (addr_sel)
		ADDR_ABS:   addr_o = {adh, adl};
		ADDR_STACK: addr_o = {STACK_PAGE, sp};
		default:    addr_o = pc_addr;
	endcase
end

assign data_o = data_sel ? p : rd;

alu alu0 (
	.func_i  (alu_func),
	.a_i     (alu_a),
	.b_i     (data_i),
	.carry_i (p[STATUS_C]),
	.y_o     (alu_y),
	.carry_o (alu_carry),
	.sign_o  (alu_sign),
	.zero_o  (alu_zero),
	.ovf_o   (alu_ovf)
);

reg_file regs0 (
	.clk_i    (clk_i),
	.arst_n_i (arst_n_i),
	.we_sel_i (reg_we_sel),
	.rd_sel_i (reg_rd_sel),
	.din_i    (alu_y),
	.adl_we_i (adl_we),
	.adh_we_i (adh_we),
	.sp_dec_i (sp_dec),
	.rd_o     (rd),
	.adl_o    (adl),
	.adh_o    (adh),
	.sp_o     (sp)
);

status_reg p0 (
	.clk_i    (clk_i),
	.arst_n_i (arst_n_i),
	.flags_i  ({alu_sign, alu_ovf, alu_zero, alu_carry}),
	.mask_i   (st_mask),
	.set_i    (st_set),
	.clr_i    (st_clr),
	.p_o      (p)
);

pc #(
	.reset_vector_p (reset_vector_p)
) pc0 (
	.clk_i     (clk_i),
	.arst_n_i  (arst_n_i),
	.inc_i     (pc_inc),
	.load_i    (pc_load),
	.load_lo_i (adl),
	.load_hi_i (data_i),
	.pc_o      (pc_addr)
);

idec idec0 (
	.opcode_i (opcode),
	.op_o     (op),
	.mode_o   (mode),
	.src_o    (src),
	.dst_o    (dst)
);

sequencer seq0 (
	.clk_i        (clk_i),
	.arst_n_i     (arst_n_i),
	.op_i         (op),
	.mode_i       (mode),
	.src_i        (src),
	.dst_i        (dst),
	.ir_we_o      (ir_we),
	.reg_we_sel_o (reg_we_sel),
	.reg_rd_sel_o (reg_rd_sel),
	.adl_we_o     (adl_we),
	.adh_we_o     (adh_we),
	.sp_dec_o     (sp_dec),
	.pc_inc_o     (pc_inc),
	.pc_load_o    (pc_load),
	.alu_func_o   (alu_func),
	.alu_src_o    (alu_src),
	.st_mask_o    (st_mask),
	.st_set_o     (st_set),
	.st_clr_o     (st_clr),
	.addr_sel_o   (addr_sel),
	.data_sel_o   (data_sel),
	.we_o         (we_o),
	.sync_o       (sync_o)
);

endmodule

// File: src/sequencer.sv
`timescale 1ns/10ps

module sequencer (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  cpu_isa_pkg::opcode_e           op_i,
	input  cpu_isa_pkg::mode_e             mode_i,
	input  cpu_isa_pkg::reg_sel_e          src_i,
	input  cpu_isa_pkg::reg_sel_e          dst_i,
	output logic                           ir_we_o,
	output cpu_isa_pkg::reg_sel_e          reg_we_sel_o,
	output cpu_isa_pkg::reg_sel_e          reg_rd_sel_o,
	output logic                           adl_we_o,
	output logic                           adh_we_o,
	output logic                           sp_dec_o,
	output logic                           pc_inc_o,
	output logic                           pc_load_o,
	output cpu_isa_pkg::alu_func_e         alu_func_o,
	output cpu_isa_pkg::alu_src_e          alu_src_o,
	output logic [cpu_cfg_pkg::DATA_W-1:0] st_mask_o,
	output logic [cpu_cfg_pkg::DATA_W-1:0] st_set_o,
	output logic [cpu_cfg_pkg::DATA_W-1:0] st_clr_o,
	output cpu_isa_pkg::addr_sel_e         addr_sel_o,
	output logic                           data_sel_o,
	output logic                           we_o,
	output logic                           sync_o
);

import cpu_cfg_pkg::*;
import cpu_isa_pkg::*;

localparam logic [DATA_W-1:0] MASK_C = DATA_W'(1) << STATUS_C;
localparam logic [DATA_W-1:0] MASK_NZ = (DATA_W'(1) << STATUS_N) | (DATA_W'(1) << STATUS_Z);
localparam logic [DATA_W-1:0] MASK_NVZC = MASK_NZ | MASK_C | (DATA_W'(1) << STATUS_V);

seq_state_e state_q;
seq_state_e state_d;
// Low for the first cycle out of reset, so the first fetch starts clean
logic       run_q;

always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i) begin
		state_q <= S_FETCH;
		run_q <= 1'b0;
	end else begin
		state_q <= state_d;
		run_q <= 1'b1;
	end
end

// In FETCH the decoder sees the opcode straight off the bus
always_comb begin
	case (state_q)
		S_FETCH: begin
			if (!run_q)
				state_d = S_FETCH;
			else if (op_i == OP_PHP)
				state_d = S_DECODE;
			else if (mode_i == MODE_ABS)
				state_d = S_ADL_FETCH;
			else
				state_d = S_OPER;
		end
		S_DECODE: state_d = S_PUSH;
		S_ADL_FETCH: state_d = S_ADH_FETCH;
		S_ADH_FETCH: begin
			if (op_i == OP_LD)
				state_d = S_MEM_READ;
			else if (op_i == OP_ST)
				state_d = S_MEM_WRITE;
			else
				state_d = S_FETCH;
		end
		default: state_d = S_FETCH;
	endcase
end

always_comb begin
	ir_we_o = 1'b0;
	reg_we_sel_o = REG_NONE;
	reg_rd_sel_o = src_i;
	adl_we_o = 1'b0;
	adh_we_o = 1'b0;
	sp_dec_o = 1'b0;
	pc_inc_o = 1'b0;
	pc_load_o = 1'b0;
	alu_func_o = ALU_PASS;
	alu_src_o = SRC_REG;
	st_mask_o = '0;
	st_set_o = '0;
	st_clr_o = '0;
	addr_sel_o = ADDR_PC;
	data_sel_o = 1'b0;
	we_o = 1'b0;
	sync_o = 1'b0;
	case (state_q)
		S_FETCH: begin
			sync_o = run_q;
			ir_we_o = run_q;
			pc_inc_o = run_q;
		end
		S_OPER: begin
			pc_inc_o = (mode_i == MODE_IMM);
			reg_we_sel_o = dst_i;
			case (op_i)
				// Zero OR operand gives the loaded byte with N and Z
				OP_LD: begin
					alu_src_o = SRC_CONST;
					alu_func_o = ALU_OR;
					st_mask_o = MASK_NZ;
				end
				OP_ADC: begin
					alu_func_o = ALU_ADD;
					st_mask_o = MASK_NVZC;
				end
				OP_SBC: begin
					alu_func_o = ALU_SUB;
					st_mask_o = MASK_NVZC;
				end
				OP_AND: begin
					alu_func_o = ALU_AND;
					st_mask_o = MASK_NZ;
				end
				OP_ORA: begin
					alu_func_o = ALU_OR;
					st_mask_o = MASK_NZ;
				end
				OP_EOR: begin
					alu_func_o = ALU_XOR;
					st_mask_o = MASK_NZ;
				end
				OP_INC: begin
					alu_func_o = ALU_INC;
					st_mask_o = MASK_NZ;
				end
				OP_DEC: begin
					alu_func_o = ALU_DEC;
					st_mask_o = MASK_NZ;
				end
				OP_XFER: st_mask_o = MASK_NZ;
				OP_CLC: st_clr_o = MASK_C;
				OP_SEC: st_set_o = MASK_C;
				default: ;
			endcase
		end
		S_ADL_FETCH: begin
			alu_src_o = SRC_DATA;
			adl_we_o = 1'b1;
			pc_inc_o = 1'b1;
		end
		S_ADH_FETCH: begin
			alu_src_o = SRC_DATA;
			if (op_i == OP_JMP) begin
				pc_load_o = 1'b1;
			end else begin
				adh_we_o = 1'b1;
				pc_inc_o = 1'b1;
			end
		end
		S_MEM_READ: begin
			addr_sel_o = ADDR_ABS;
			alu_src_o = SRC_CONST;
			alu_func_o = ALU_OR;
			reg_we_sel_o = dst_i;
			st_mask_o = MASK_NZ;
		end
		S_MEM_WRITE: begin
			addr_sel_o = ADDR_ABS;
			we_o = 1'b1;
		end
		S_PUSH: begin
			addr_sel_o = ADDR_STACK;
			data_sel_o = 1'b1;
			we_o = 1'b1;
			sp_dec_o = 1'b1;
		end
		default: ;
	endcase
end

endmodule

// File: src/idec.sv
`timescale 1ns/10ps

module idec (
	input  logic [cpu_cfg_pkg::DATA_W-1:0] opcode_i,
	output cpu_isa_pkg::opcode_e           op_o,
	output cpu_isa_pkg::mode_e             mode_o,
	output cpu_isa_pkg::reg_sel_e          src_o,
	output cpu_isa_pkg::reg_sel_e          dst_o
);

import cpu_isa_pkg::*;

// Unknown opcodes fall through to NOP
always_comb begin
	case (opcode_i)
		8'hA9, 8'hA2, 8'hA0, 8'hAD: op_o = OP_LD;
		8'h8D, 8'h8E, 8'h8C: op_o = OP_ST;
		8'h69: op_o = OP_ADC;
		8'hE9: op_o = OP_SBC;
		8'h29: op_o = OP_AND;
		8'h09: op_o = OP_ORA;
		8'h49: op_o = OP_EOR;
		8'hE8, 8'hC8: op_o = OP_INC;
		8'hCA, 8'h88: op_o = OP_DEC;
		8'hAA, 8'hA8, 8'h8A, 8'h98: op_o = OP_XFER;
		8'h9A: op_o = OP_TXS;
		8'h18: op_o = OP_CLC;
		8'h38: op_o = OP_SEC;
		8'h08: op_o = OP_PHP;
		8'h4C: op_o = OP_JMP;
		default: op_o = OP_NOP;
	endcase
end

always_comb begin
	case (opcode_i)
		8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49: mode_o = MODE_IMM;
		8'hAD, 8'h8D, 8'h8E, 8'h8C, 8'h4C: mode_o = MODE_ABS;
		default: mode_o = MODE_IMP;
	endcase
end

always_comb begin
	case (opcode_i)
		8'h8D, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hAA, 8'hA8: src_o = REG_A;
		8'h8E, 8'hE8, 8'hCA, 8'h8A, 8'h9A: src_o = REG_X;
		8'h8C, 8'hC8, 8'h88, 8'h98: src_o = REG_Y;
		8'h08: src_o = REG_P;
		default: src_o = REG_NONE;
	endcase
end

always_comb begin
	case (opcode_i)
		8'hA9, 8'hAD, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'h8A, 8'h98: dst_o = REG_A;
		8'hA2, 8'hE8, 8'hCA, 8'hAA: dst_o = REG_X;
		8'hA0, 8'hC8, 8'h88, 8'hA8: dst_o = REG_Y;
		8'h9A: dst_o = REG_SP;
		default: dst_o = REG_NONE;
	endcase
end

endmodule

// File: src/pc.sv
`timescale 1ns/10ps

module pc #(
	parameter logic [cpu_cfg_pkg::ADDR_W-1:0] reset_vector_p = cpu_cfg_pkg::RESET_VECTOR
) (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  logic                           inc_i,
	input  logic                           load_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] load_lo_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] load_hi_i,
	output logic [cpu_cfg_pkg::ADDR_W-1:0] pc_o
);

import cpu_cfg_pkg::*;

logic [ADDR_W-1:0] pc_q;

// Load wins over increment
always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i)
		pc_q <= reset_vector_p;
	else if (load_i)
		pc_q <= {load_hi_i, load_lo_i};
	else if (inc_i)
		pc_q <= pc_q + ADDR_W'(1);
end

assign pc_o = pc_q;

endmodule

// File: src/status_reg.sv
`timescale 1ns/10ps

module status_reg (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  logic [3:0]                     flags_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] mask_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] set_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] clr_i,
	output logic [cpu_cfg_pkg::DATA_W-1:0] p_o
);

import cpu_cfg_pkg::*;

localparam int                P_ONE_BIT = 5;
localparam logic [DATA_W-1:0] P_RESET = 8'h20;

logic [DATA_W-1:0] p_q;
logic [DATA_W-1:0] flag_vec;
logic [DATA_W-1:0] p_d;

always_comb begin
	// flags_i is {N, V, Z, C}
	flag_vec = '0;
	flag_vec[STATUS_N] = flags_i[3];
	flag_vec[STATUS_V] = flags_i[2];
	flag_vec[STATUS_Z] = flags_i[1];
	flag_vec[STATUS_C] = flags_i[0];
	p_d = ((p_q & ~mask_i) | (flag_vec & mask_i) | set_i) & ~clr_i;
	p_d[P_ONE_BIT] = 1'b1;
	// No interrupt support, so B and I stay clear
	p_d[STATUS_B] = 1'b0;
	p_d[STATUS_I] = 1'b0;
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i)
		p_q <= P_RESET;
	else
		p_q <= p_d;
end

assign p_o = p_q;

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic                           clk_i,
	input  logic                           arst_n_i,
	input  cpu_isa_pkg::reg_sel_e          we_sel_i,
	input  cpu_isa_pkg::reg_sel_e          rd_sel_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] din_i,
	input  logic                           adl_we_i,
	input  logic                           adh_we_i,
	input  logic                           sp_dec_i,
	output logic [cpu_cfg_pkg::DATA_W-1:0] rd_o,
	output logic [cpu_cfg_pkg::DATA_W-1:0] adl_o,
	output logic [cpu_cfg_pkg::DATA_W-1:0] adh_o,
	output logic [cpu_cfg_pkg::DATA_W-1:0] sp_o
);

import cpu_cfg_pkg::*;
import cpu_isa_pkg::*;

logic [DATA_W-1:0] a_q;
logic [DATA_W-1:0] x_q;
logic [DATA_W-1:0] y_q;
logic [DATA_W-1:0] sp_q;
logic [DATA_W-1:0] adl_q;
logic [DATA_W-1:0] adh_q;

always_ff @(posedge clk_i or negedge arst_n_i) begin
	if (!arst_n_i) begin
		a_q <= '0;
		x_q <= '0;
		y_q <= '0;
		sp_q <= '1;
	end else begin
		case (we_sel_i)
			REG_A:  a_q <= din_i;
			REG_X:  x_q <= din_i;
			REG_Y:  y_q <= din_i;
			REG_SP: sp_q <= din_i;
			default: ;
		endcase
		// Post-decrement after a push
		if (sp_dec_i)
			sp_q <= sp_q - DATA_W'(1);
	end
end

// Address latches for absolute operands
always_ff @(posedge clk_i) begin
	if (adl_we_i)
		adl_q <= din_i;
	if (adh_we_i)
		adh_q <= din_i;
end

always_comb begin
	case (rd_sel_i)
		REG_A:  rd_o = a_q;
		REG_X:  rd_o = x_q;
		REG_Y:  rd_o = y_q;
		REG_SP: rd_o = sp_q;
		default: rd_o = '0;
	endcase
end

assign adl_o = adl_q;
assign adh_o = adh_q;
assign sp_o = sp_q;

endmodule

// File: src/alu.sv
`timescale 1ns/10ps

module alu (
	input  cpu_isa_pkg::alu_func_e         func_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] a_i,
	input  logic [cpu_cfg_pkg::DATA_W-1:0] b_i,
	input  logic                           carry_i,
	output logic [cpu_cfg_pkg::DATA_W-1:0] y_o,
	output logic                           carry_o,
	output logic                           sign_o,
	output logic                           zero_o,
	output logic                           ovf_o
);

import cpu_cfg_pkg::*;
import cpu_isa_pkg::*;

// Constant generator for INC and DEC
localparam logic [DATA_W-1:0] CONST_ONE = DATA_W'(1);

logic [DATA_W-1:0] add_b;
logic              add_c;
logic [DATA_W:0]   sum;
logic              arith;

always_comb begin
	add_b = b_i;
	add_c = carry_i;
	case (func_i)
		ALU_SUB: add_b = ~b_i;
		ALU_INC: begin
			add_b = CONST_ONE;
			add_c = 1'b0;
		end
		// a - 1 as a + ~1 + 1
		ALU_DEC: begin
			add_b = ~CONST_ONE;
			add_c = 1'b1;
		end
		default: ;
	endcase
end

assign sum = {1'b0, a_i} + {1'b0, add_b} + {{DATA_W{1'b0}}, add_c};
assign arith = (func_i == ALU_ADD) || (func_i == ALU_SUB) ||
	(func_i == ALU_INC) || (func_i == ALU_DEC);

always_comb begin
	case (func_i)
		ALU_AND: y_o = a_i & b_i;
		ALU_OR:  y_o = a_i | b_i;
		ALU_XOR: y_o = a_i ^ b_i;
		ALU_PASS: y_o = a_i;
		default: y_o = sum[DATA_W-1:0];
	endcase
end

assign carry_o = arith & sum[DATA_W];
// Signed overflow when both operands agree in sign and the result does not
assign ovf_o = arith & (a_i[DATA_W-1] == add_b[DATA_W-1]) &
	(sum[DATA_W-1] != a_i[DATA_W-1]);
assign sign_o = y_o[DATA_W-1];
assign zero_o = (y_o == '0);

endmodule

// File: src/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// Operation classes after decode
	typedef enum logic [3:0] {
		OP_LD,
		OP_ST,
		OP_ADC,
		OP_SBC,
		OP_AND,
		OP_ORA,
		OP_EOR,
		OP_INC,
		OP_DEC,
		OP_XFER,
		OP_TXS,
		OP_CLC,
		OP_SEC,
		OP_PHP,
		OP_JMP,
		OP_NOP
	} opcode_e;

	typedef enum logic [1:0] {
		MODE_IMP,
		MODE_IMM,
		MODE_ABS
	} mode_e;

	typedef enum logic [2:0] {
		REG_A,
		REG_X,
		REG_Y,
		REG_SP,
		REG_P,
		REG_NONE
	} reg_sel_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_DEC,
		ALU_PASS
	} alu_func_e;

	typedef enum logic [1:0] {
		SRC_REG,
		SRC_DATA,
		SRC_CONST
	} alu_src_e;

	// Memory address source
	typedef enum logic [1:0] {
		ADDR_PC,
		ADDR_ABS,
		ADDR_STACK
	} addr_sel_e;

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_OPER,
		S_ADL_FETCH,
		S_ADH_FETCH,
		S_MEM_READ,
		S_MEM_WRITE,
		S_PUSH
	} seq_state_e;

endpackage

// File: src/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	// Status register bit positions
	localparam int STATUS_C = 0;
	localparam int STATUS_Z = 1;
	localparam int STATUS_I = 2;
	localparam int STATUS_B = 4;
	localparam int STATUS_V = 6;
	localparam int STATUS_N = 7;

	localparam logic [DATA_W-1:0] STACK_PAGE = 8'h01;
	localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'h0000;

endpackage
